// File: verilog/blur_pkg.sv
package blur_pkg;

    // one greyscale sample
    typedef logic [7:0] pixel_t;

    // window side
    localparam int KERNEL_SIZE = 5;

    // 255 * 159 still fits in 16 bits
    localparam int SUM_WIDTH = 16;

    // full weight sum is 159
    localparam int WEIGHT_WIDTH = 8;

    typedef logic [SUM_WIDTH-1:0]    sum_t;
    typedef logic [WEIGHT_WIDTH-1:0] weight_t;

    // gaussian weights, row major, total 159
    localparam logic [3:0] KERNEL [KERNEL_SIZE][KERNEL_SIZE] = '{
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd5, 4'd12, 4'd15, 4'd12, 4'd5},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2}
    };

    // blur control phases
    typedef enum logic [2:0] {
        prologue,
        filter,
        divide,
        emit
    } blur_state_t;

    // divider control
    typedef enum logic {
        idle,
        busy
    } div_state_t;

endpackage

// File: verilog/pixel_fifo.sv
module pixel_fifo #(
    parameter int depth = 16
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  blur_pkg::pixel_t wr_din,
    output logic             wr_full,
    input  logic             rd_en,
    output blur_pkg::pixel_t rd_dout,
    output logic             rd_empty
);
    import blur_pkg::*;

    // depth is a power of two, so the pointers wrap on their own
    localparam int addr_bits = $clog2(depth);

    // storage
    pixel_t mem [depth];

    // one extra bit tells full from empty
    logic [addr_bits:0] wr_ptr;
    logic [addr_bits:0] rd_ptr;

    // same address, same lap
    assign rd_empty = (wr_ptr == rd_ptr);

    // same address, writer one lap ahead
    assign wr_full = (wr_ptr[addr_bits] != rd_ptr[addr_bits]) &&
                     (wr_ptr[addr_bits-1:0] == rd_ptr[addr_bits-1:0]);

    // show-ahead: oldest entry always on the output
    assign rd_dout = mem[rd_ptr[addr_bits-1:0]];

    // pointer update
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // data write
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr[addr_bits-1:0]] <= wr_din;
        end
    end

    // writer must respect full
    overflow_check: assert property (@(posedge clock) disable iff (reset)
        wr_en |-> !wr_full);

    // reader must respect empty
    underflow_check: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> !rd_empty);

endmodule

// File: verilog/seq_divider.sv
module seq_divider (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  blur_pkg::sum_t    dividend,
    input  blur_pkg::weight_t divisor,
    output logic              done,
    output blur_pkg::sum_t    quotient,
    output blur_pkg::weight_t remainder
);
    import blur_pkg::*;

    // counts 0 .. SUM_WIDTH, last value is the finish cycle
    localparam int count_bits = $clog2(SUM_WIDTH + 1);
    localparam logic [count_bits-1:0] last_count = count_bits'(SUM_WIDTH);

    div_state_t state;
    logic [count_bits-1:0] bit_count;

    // working registers
    sum_t    quot_reg;
    weight_t rem_reg;
    weight_t divisor_reg;

    // remainder with next dividend bit shifted in
    logic [WEIGHT_WIDTH:0] partial;
    logic fits;
    logic iterate;

    assign partial = {rem_reg, quot_reg[SUM_WIDTH-1]};
    assign fits    = (partial >= {1'b0, divisor_reg});
    assign iterate = (state == busy) && (bit_count != last_count);

    assign quotient  = quot_reg;
    assign remainder = rem_reg;

    // control
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= idle;
            bit_count <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state     <= busy;
                        bit_count <= '0;
                    end
                end
                busy: begin
                    if (bit_count == last_count) begin
                        // one spare cycle after the last bit
                        state <= idle;
                        done  <= 1'b1;
                    end else begin
                        bit_count <= bit_count + 1'b1;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // restoring shift-subtract, msb first
    always_ff @(posedge clock) begin
        if (state == idle && start) begin
            quot_reg    <= dividend;
            rem_reg     <= '0;
            divisor_reg <= divisor;
        end else if (iterate) begin
            quot_reg <= {quot_reg[SUM_WIDTH-2:0], fits};
            // true difference is below divisor, so 8 bits hold it
            rem_reg  <= fits ? partial[WEIGHT_WIDTH-1:0] - divisor_reg
                             : partial[WEIGHT_WIDTH-1:0];
        end
    end

    // caller never divides by zero
    divisor_check: assert property (@(posedge clock) disable iff (reset)
        start |-> divisor != '0);

    // caller waits for done before the next start
    start_check: assert property (@(posedge clock) disable iff (reset)
        start |-> state == idle);

endmodule

// File: verilog/gaussian_blur.sv
module gaussian_blur #(
    parameter int width  = 8,
    parameter int height = 6
) (
    input  logic             clock,
    input  logic             reset,
    output logic             in_rd_en,
    input  logic             in_empty,
    input  blur_pkg::pixel_t in_dout,
    output logic             out_wr_en,
    input  logic             out_full,
    output blur_pkg::pixel_t out_din
);
    import blur_pkg::*;

    // four full rows plus one window row
    localparam int shift_len    = (KERNEL_SIZE - 1) * width + KERNEL_SIZE;
    localparam int half         = KERNEL_SIZE / 2;
    // pixels needed before (0,0) sits in the window centre
    localparam int prologue_len = half * width + half + 1;
    localparam int pixel_count  = width * height;

    localparam int cnt_bits = $clog2(pixel_count + 1);
    localparam int row_bits = $clog2(height + 1);
    localparam int col_bits = $clog2(width + 1);

    blur_state_t state;
    blur_state_t next_state;

    // line buffer with the oldest pixel at index 0
    pixel_t shift_reg [shift_len];

    // frame counters
    logic [cnt_bits-1:0] consumed;
    logic [row_bits-1:0] row;
    logic [col_bits-1:0] col;

    // which window rows and columns land inside the image
    logic [KERNEL_SIZE-1:0] row_ok;
    logic [KERNEL_SIZE-1:0] col_ok;

    // per column partial sums
    sum_t    col_sum    [KERNEL_SIZE];
    weight_t col_weight [KERNEL_SIZE];
    sum_t    win_sum;
    weight_t win_weight;

    // divider operands held through the division
    sum_t    sum_reg;
    weight_t weight_reg;

    logic   start;
    logic   div_done;
    sum_t   quotient;

    logic   pad_phase;
    logic   last_pixel;
    logic   shift_en;
    logic   advance;
    pixel_t shift_in;

    // whole frame already taken from the input
    assign pad_phase  = (consumed == cnt_bits'(pixel_count));
    // row steps past the bottom after the final window
    assign last_pixel = (row == row_bits'(height));
    // zero padding at the tail of the frame
    assign shift_in   = pad_phase ? '0 : in_dout;

    // border masks
    always_comb begin
        for (int i = 0; i < KERNEL_SIZE; i++) begin
            row_ok[i] = (int'(row) + i - half >= 0) && (int'(row) + i - half < height);
            col_ok[i] = (int'(col) + i - half >= 0) && (int'(col) + i - half < width);
        end
    end

    // masked multiply-accumulate over the window
    always_comb begin
        win_sum    = '0;
        win_weight = '0;
        for (int j = 0; j < KERNEL_SIZE; j++) begin
            col_sum[j]    = '0;
            col_weight[j] = '0;
            for (int i = 0; i < KERNEL_SIZE; i++) begin
                if (row_ok[i] && col_ok[j]) begin
                    col_sum[j] = col_sum[j] +
                                 sum_t'(shift_reg[i * width + j]) * sum_t'(KERNEL[i][j]);
                    col_weight[j] = col_weight[j] + weight_t'(KERNEL[i][j]);
                end
            end
            // fold the column into the window total
            win_sum    = win_sum + col_sum[j];
            win_weight = win_weight + col_weight[j];
        end
    end

    // next state and handshakes
    always_comb begin
        next_state = state;
        in_rd_en   = 1'b0;
        shift_en   = 1'b0;
        advance    = 1'b0;
        out_wr_en  = 1'b0;
        case (state)
            prologue: begin
                // fill the buffer up to the first centre pixel
                if (!in_empty) begin
                    in_rd_en = 1'b1;
                    shift_en = 1'b1;
                    if (consumed == cnt_bits'(prologue_len - 1)) begin
                        next_state = filter;
                    end
                end
            end
            filter: begin
                // stall only while real pixels are still owed
                if (pad_phase || !in_empty) begin
                    in_rd_en   = !pad_phase;
                    shift_en   = 1'b1;
                    advance    = 1'b1;
                    next_state = divide;
                end
            end
            divide: begin
                if (div_done) begin
                    next_state = emit;
                end
            end
            emit: begin
                // back-pressure from the output FIFO
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = last_pixel ? prologue : filter;
                end
            end
            default: begin
                next_state = prologue;
            end
        endcase
    end

    // control registers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= prologue;
            consumed <= '0;
            row      <= '0;
            col      <= '0;
            start    <= 1'b0;
        end else begin
            state <= next_state;
            // one cycle start pulse after each window
            start <= advance;
            if (in_rd_en) begin
                consumed <= consumed + 1'b1;
            end
            if (advance) begin
                if (col == col_bits'(width - 1)) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
            // end of frame clears the counters but not the line buffer
            if (out_wr_en && last_pixel) begin
                consumed <= '0;
                row      <= '0;
                col      <= '0;
            end
        end
    end

    // line buffer shift and divider operands
    always_ff @(posedge clock) begin
        if (shift_en) begin
            for (int k = 0; k < shift_len - 1; k++) begin
                shift_reg[k] <= shift_reg[k + 1];
            end
            shift_reg[shift_len - 1] <= shift_in;
        end
        if (advance) begin
            sum_reg    <= win_sum;
            weight_reg <= win_weight;
        end
    end

    seq_divider u_divider (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .dividend  (sum_reg),
        .divisor   (weight_reg),
        .done      (div_done),
        .quotient  (quotient),
        .remainder ()
    );

    // clamp to pixel range
    assign out_din = (quotient > sum_t'(255)) ? 8'hff : quotient[7:0];

    // bottom row is only finished once the whole frame has been taken in
    frame_check: assert property (@(posedge clock) disable iff (reset)
        last_pixel |-> pad_phase);

    // the divider reports only while the filter waits on it
    done_check: assert property (@(posedge clock) disable iff (reset)
        div_done |-> state == divide);

endmodule

// File: verilog/blur_top.sv
module blur_top #(
    parameter int width  = 8,
    parameter int height = 6
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             in_wr_en,
    input  blur_pkg::pixel_t in_din,
    output logic             in_full,
    input  logic             out_rd_en,
    output blur_pkg::pixel_t out_dout,
    output logic             out_empty
);
    import blur_pkg::*;

    // input FIFO to blur
    logic   src_rd_en;
    logic   src_empty;
    pixel_t src_pixel;

    // blur to output FIFO
    logic   snk_wr_en;
    logic   snk_full;
    pixel_t snk_pixel;

    // raster pixels in
    pixel_fifo #(
        .depth (16)
    ) u_in_fifo (
        .clock    (clock),
        .reset    (reset),
        .wr_en    (in_wr_en),
        .wr_din   (in_din),
        .wr_full  (in_full),
        .rd_en    (src_rd_en),
        .rd_dout  (src_pixel),
        .rd_empty (src_empty)
    );

    gaussian_blur #(
        .width  (width),
        .height (height)
    ) u_blur (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (src_rd_en),
        .in_empty  (src_empty),
        .in_dout   (src_pixel),
        .out_wr_en (snk_wr_en),
        .out_full  (snk_full),
        .out_din   (snk_pixel)
    );

    // blurred pixels out, small so back-pressure shows up quickly
    pixel_fifo #(
        .depth (4)
    ) u_out_fifo (
        .clock    (clock),
        .reset    (reset),
        .wr_en    (snk_wr_en),
        .wr_din   (snk_pixel),
        .wr_full  (snk_full),
        .rd_en    (out_rd_en),
        .rd_dout  (out_dout),
        .rd_empty (out_empty)
    );

endmodule

// File: sim/blur_ref.svh
`ifndef BLUR_REF_SVH
`define BLUR_REF_SVH

// kinds of test image
typedef enum {
    pat_const,
    pat_ramp,
    pat_checker,
    pat_random,
    pat_max
} pattern_t;

// frame being built, read back by the blur model
pixel_t frame_img [img_h][img_w];

// one source pixel, later frames get shifted values
function automatic pixel_t source_pixel(pattern_t pattern, int frame, int r, int c);
    case (pattern)
        pat_const:   return pixel_t'(100 + 37 * frame);
        // mostly horizontal, small vertical slope
        pat_ramp:    return pixel_t'(32 * c + 3 * r + 50 * frame);
        pat_checker: return ((r + c + frame) % 2 == 1) ? 8'd230 : 8'd15;
        pat_random:  return pixel_t'($urandom);
        default:     return 8'hff;
    endcase
endfunction

// weighted mean over the taps that land inside the image
function automatic pixel_t blur_pixel(int r, int c);
    int acc;
    int weights;
    int rr;
    int cc;
    acc     = 0;
    weights = 0;
    for (int i = 0; i < KERNEL_SIZE; i++) begin
        for (int j = 0; j < KERNEL_SIZE; j++) begin
            rr = r + i - KERNEL_SIZE / 2;
            cc = c + j - KERNEL_SIZE / 2;
            // off-image taps drop out of both sums
            if (rr >= 0 && rr < img_h && cc >= 0 && cc < img_w) begin
                acc     += int'(KERNEL[i][j]) * int'(frame_img[rr][cc]);
                weights += int'(KERNEL[i][j]);
            end
        end
    end
    // floor division, then clamp
    acc = acc / weights;
    return (acc > 255) ? 8'hff : pixel_t'(acc);
endfunction

// one frame of input pixels and its expected output, raster order
task automatic queue_frame(pattern_t pattern, int frame);
    for (int r = 0; r < img_h; r++) begin
        for (int c = 0; c < img_w; c++) begin
            frame_img[r][c] = source_pixel(pattern, frame, r, c);
            in_q.push_back(frame_img[r][c]);
        end
    end
    for (int r = 0; r < img_h; r++) begin
        for (int c = 0; c < img_w; c++) begin
            exp_q.push_back(blur_pixel(r, c));
        end
    end
endtask

`endif

// File: sim/blur_tb.sv
module blur_tb;
    import blur_pkg::*;

    localparam int img_w        = 8;
    localparam int img_h        = 6;
    localparam int frame_pixels = img_w * img_h;
    // longest stretch any single wait may take
    localparam int wait_limit   = 2000;
    // quiet window after each frame
    localparam int idle_cycles  = 100;
    localparam int num_tests    = 8;

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    pixel_t out_dout;
    logic   out_empty;

    // pixels still to send and pixels still owed by the DUT
    pixel_t in_q [$];
    pixel_t exp_q [$];

    int errors;
    int drained;
    int pass_count;
    int fail_count;
    bit timed_out;
    bit full_seen;

    `include "blur_ref.svh"

    typedef enum {
        stall_none,
        stall_periodic,
        stall_random
    } stall_t;

    typedef struct packed {
        pattern_t pattern;
        stall_t   stall;
        int       count;
    } test_t;

    // two frames worth of count means frames back to back
    localparam test_t tests [num_tests] = '{
        '{pat_const,   stall_none,     frame_pixels},
        '{pat_ramp,    stall_none,     frame_pixels},
        '{pat_checker, stall_none,     frame_pixels},
        '{pat_random,  stall_none,     frame_pixels},
        '{pat_max,     stall_none,     frame_pixels},
        '{pat_ramp,    stall_periodic, frame_pixels},
        '{pat_random,  stall_random,   frame_pixels},
        '{pat_random,  stall_none,     2 * frame_pixels}
    };
    string test_names [num_tests] = '{"constant", "ramp", "checker", "random", "all_255",
                                      "ramp_periodic_stall", "random_random_stall",
                                      "two_frames"};

    blur_top #(
        .width  (img_w),
        .height (img_h)
    ) i_dut (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic check_pixel(string name, pixel_t expected, pixel_t actual);
        if (expected !== actual) begin
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        if (expected != actual) begin
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (expected !== actual) begin
            $display("[FAIL] t=%0t %s expected %0b got %0b", $time, name, expected, actual);
            errors++;
        end
    endtask

    // writes while the input FIFO has room
    task automatic feed_pixels();
        int waited;
        waited = 0;
        while (in_q.size() > 0 && !timed_out) begin
            @(posedge clock);
            #2;
            if (!in_full) begin
                in_din   = in_q.pop_front();
                in_wr_en = 1'b1;
                waited   = 0;
            end else begin
                in_wr_en  = 1'b0;
                full_seen = 1'b1;
                waited++;
                if (waited > wait_limit) begin
                    $display("timeout: input FIFO stayed full for %0d cycles", wait_limit);
                    timed_out = 1'b1;
                end
            end
        end
        @(posedge clock);
        #2;
        in_wr_en = 1'b0;
    endtask

    // pops when data is shown and the stall mode lets it through
    task automatic drain_pixels(stall_t stall, int count);
        int waited;
        int cycle;
        bit allow;
        waited  = 0;
        cycle   = 0;
        drained = 0;
        while (drained < count && !timed_out) begin
            @(posedge clock);
            #2;
            cycle++;
            case (stall)
                stall_none:     allow = 1'b1;
                // long blocked stretch fills the output FIFO
                stall_periodic: allow = (cycle % 128) >= 120;
                default:        allow = ($urandom % 32) == 0;
            endcase
            if (!out_empty && allow) begin
                check_pixel($sformatf("out_dout[%0d]", drained), exp_q.pop_front(), out_dout);
                out_rd_en = 1'b1;
                drained++;
                waited = 0;
            end else begin
                out_rd_en = 1'b0;
                waited++;
                if (waited > wait_limit) begin
                    $display("timeout: no output pixel for %0d cycles after %0d of %0d",
                             wait_limit, drained, count);
                    timed_out = 1'b1;
                end
            end
        end
        @(posedge clock);
        #2;
        out_rd_en = 1'b0;
    endtask

    // nothing more may come out after the frame
    task automatic watch_idle(output int extra);
        extra = 0;
        for (int n = 0; n < idle_cycles; n++) begin
            @(posedge clock);
            #2;
            out_rd_en = !out_empty;
            if (!out_empty) begin
                extra++;
            end
        end
        @(posedge clock);
        #2;
        out_rd_en = 1'b0;
    endtask

    initial begin
        test_t cur;
        int    extra;
        void'($urandom(32'hc1825e06));
        reset      = 1'b1;
        in_wr_en   = 1'b0;
        in_din     = '0;
        out_rd_en  = 1'b0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        full_seen  = 1'b0;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;

        for (int t = 0; t < num_tests; t++) begin
            cur = tests[t];
            if (timed_out) begin
                $display("test %0d %s: skipped after timeout", t, test_names[t]);
                fail_count++;
            end else begin
                errors    = 0;
                full_seen = 1'b0;
                for (int f = 0; f < cur.count / frame_pixels; f++) begin
                    queue_frame(cur.pattern, f);
                end
                // feeder and drain run side by side
                fork
                    feed_pixels();
                    drain_pixels(cur.stall, cur.count);
                join
                watch_idle(extra);
                check_count("out_dout pixel count", cur.count, drained + extra);
                check_count("out_empty idle pixels", 0, extra);
                // a frame outruns the filter so the input FIFO has to fill up
                check_flag("in_full reached", 1'b1, full_seen);
                if (errors == 0 && !timed_out) begin
                    $display("test %0d %s: passed, %0d pixels", t, test_names[t], drained);
                    pass_count++;
                end else begin
                    $display("test %0d %s: failed, %0d errors", t, test_names[t], errors);
                    fail_count++;
                end
            end
        end

        $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+sim
verilog/blur_pkg.sv
verilog/pixel_fifo.sv
verilog/seq_divider.sv
verilog/gaussian_blur.sv
verilog/blur_top.sv
sim/blur_tb.sv

// File: run.sh
#!/bin/sh
# build the blur testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module blur_tb -o blur_sim &&
./obj_dir/blur_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "blur run: pass" || { echo "blur run: fail"; exit 1; }
